// File: filelist.f
source/cluster_pkg.sv
source/frame_receiver.sv
source/priority_tree.sv
source/result_fifo.sv
source/result_sender.sv
source/cluster_select_top.sv
tests/clock_gen.sv
tests/tb_cluster_select.sv

// File: Makefile
TOP := tb_cluster_select

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_cluster_select.sv
`timescale 1ns/1ns
module tb_cluster_select
    import cluster_pkg::*;
;

    localparam int NUM_PADS   = 24;
    localparam int ADR_BITS   = 5;
    localparam int FIFO_DEPTH = 8;
    localparam int CNT_BITS   = $bits(pad_cnt_t);
    localparam int CNT_W      = NUM_PADS * CNT_BITS;
    localparam int RES_BITS   = $bits(pass_t) + 1 + CNT_BITS + ADR_BITS;
    localparam int NUM_FRAMES = 200;
    localparam int MAX_CYCLES = NUM_FRAMES * 40;

    logic                clock;
    logic                arst_n;
    logic                in_req;
    logic [NUM_PADS-1:0] in_vpfs;
    logic [CNT_W-1:0]    in_cnts;
    pass_t               in_pass;
    logic                in_ack;
    logic                out_req;
    logic                out_ack;
    pass_t               out_pass;
    logic                out_vpf;
    pad_cnt_t            out_cnt;
    logic [ADR_BITS-1:0] out_adr;

    integer              seed = 14;
    integer              ack_seed = 14;
    int                  error_count = 0;
    int                  frames_sent = 0;
    int                  frames_received = 0;
    int                  cycle_count = 0;
    logic [RES_BITS-1:0] expected_q [$];

    clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (8)
    ) clock_gen_i (
        .clock  (clock),
        .arst_n (arst_n)
    );

    cluster_select_top #(
        .NUM_PADS   (NUM_PADS),
        .ADR_BITS   (ADR_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) cluster_select_top_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_vpfs  (in_vpfs),
        .in_cnts  (in_cnts),
        .in_pass  (in_pass),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_pass (out_pass),
        .out_vpf  (out_vpf),
        .out_cnt  (out_cnt),
        .out_adr  (out_adr)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Mostly sparse frames, some empty, some with a single pad anywhere
    task automatic make_frame(output logic [NUM_PADS-1:0] vpfs, output logic [CNT_W-1:0] cnts,
                              output pass_t pass);
        int mode;
        mode = $unsigned($random(seed)) % 8;
        for (int i = 0; i < NUM_PADS; i++) begin
            vpfs[i] = (mode > 1) && ($unsigned($random(seed)) % 3 == 0);
            cnts[i*CNT_BITS +: CNT_BITS] = CNT_BITS'($random(seed));
        end
        if (mode == 1) begin
            vpfs[$unsigned($random(seed)) % NUM_PADS] = 1'b1;
        end
        pass = pass_t'($random(seed));
    endtask

    // Reference model scans for the first flagged pad
    function automatic logic [RES_BITS-1:0] expected_result(input logic [NUM_PADS-1:0] vpfs,
                                                            input logic [CNT_W-1:0] cnts,
                                                            input pass_t pass);
        logic                found;
        pad_cnt_t            cnt;
        logic [ADR_BITS-1:0] adr;
        found = 1'b0;
        cnt   = '0;
        adr   = '1;
        for (int i = 0; i < NUM_PADS; i++) begin
            if (!found && vpfs[i]) begin
                found = 1'b1;
                cnt   = cnts[i*CNT_BITS +: CNT_BITS];
                adr   = ADR_BITS'(i);
            end
        end
        return {pass, found, cnt, adr};
    endfunction

    // Compare one output transfer against the oldest expected result
    task automatic take_result(output logic [RES_BITS-1:0] held);
        logic [RES_BITS-1:0] exp;
        held = {out_pass, out_vpf, out_cnt, out_adr};
        if (expected_q.size() == 0) begin
            $display("Result at %0t ns arrived while no frame was expected", $time);
            error_count++;
        end else begin
            exp = expected_q.pop_front();
            check_value(out_pass, exp[RES_BITS-1 -: 3], "pass tag");
            check_value(out_vpf, exp[CNT_BITS+ADR_BITS], "vpf");
            check_value(out_cnt, exp[ADR_BITS +: CNT_BITS], "count");
            check_value(out_adr, exp[ADR_BITS-1:0], "address");
        end
        frames_received++;
    endtask

    //--------------------------------------------------
    // Source and end of run
    //--------------------------------------------------
    initial begin
        logic [NUM_PADS-1:0] vpfs;
        logic [CNT_W-1:0]    cnts;
        pass_t               pass;
        int                  gap;
        in_req  = 1'b0;
        in_vpfs = '0;
        in_cnts = '0;
        in_pass = '0;
        out_ack = 1'b0;
        @(posedge arst_n);
        // Quiet period after reset
        repeat (20) begin
            @(posedge clock);
            check_value(in_ack, 1'b0, "in_ack while idle");
            check_value(out_req, 1'b0, "out_req while idle");
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            make_frame(vpfs, cnts, pass);
            @(posedge clock);
            in_vpfs <= vpfs;
            in_cnts <= cnts;
            in_pass <= pass;
            @(posedge clock);
            in_req <= 1'b1;
            @(posedge clock);
            while (!in_ack) @(posedge clock);
            expected_q.push_back(expected_result(vpfs, cnts, pass));
            frames_sent++;
            in_req  <= 1'b0;
            // Frame is held inside the DUT now
            in_vpfs <= NUM_PADS'($random(seed));
            in_cnts <= CNT_W'({$random(seed), $random(seed), $random(seed)});
            @(posedge clock);
            while (in_ack) @(posedge clock);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(posedge clock);
        end
        while (frames_received < NUM_FRAMES) @(posedge clock);
        repeat (20) @(posedge clock);
        check_value(expected_q.size(), 0, "frames left without a result");
        check_value(frames_received, frames_sent, "results against frames");
        $display("Errors: %0d, frames sent: %0d, results received: %0d",
                 error_count, frames_sent, frames_received);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    //--------------------------------------------------
    // Sink with random acknowledge delay
    //--------------------------------------------------
    initial begin
        logic [RES_BITS-1:0] held;
        int                  delay;
        @(posedge arst_n);
        forever begin
            @(posedge clock);
            if (out_req) begin
                take_result(held);
                delay = $unsigned($random(ack_seed)) % 7;
                repeat (delay) begin
                    @(posedge clock);
                    check_value(out_req, 1'b1, "out_req dropped before out_ack");
                    check_value({out_pass, out_vpf, out_cnt, out_adr}, held,
                                "output data while out_req high");
                end
                out_ack <= 1'b1;
                @(posedge clock);
                while (out_req) @(posedge clock);
                out_ack <= 1'b0;
            end
        end
    end

    // Input link four-phase rule
    initial begin
        logic ack_prev;
        ack_prev = 1'b0;
        forever begin
            @(posedge clock);
            if (arst_n) begin
                if (in_ack && !ack_prev && !in_req) begin
                    $display("Handshake error at %0t ns, in_ack rose with in_req low", $time);
                    error_count++;
                end
                if (!in_ack && ack_prev && in_req) begin
                    $display("Handshake error at %0t ns, in_ack fell with in_req high", $time);
                    error_count++;
                end
            end
            ack_prev = in_ack;
        end
    end

    // Run limit
    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, only %0d of %0d results arrived",
                 cycle_count, frames_received, NUM_FRAMES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ns
module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock = ~clock;
        end
    end

    // Release reset on a falling edge, clear of the capture edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

// File: source/cluster_select_top.sv
`timescale 1ns/1ns
module cluster_select_top
    import cluster_pkg::*;
#(
    parameter int NUM_PADS   = 24,
    parameter int ADR_BITS   = 5,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                   clock,
    input  logic                                   arst_n,

    input  logic                                   in_req,
    input  logic [NUM_PADS-1:0]                    in_vpfs,
    input  logic [NUM_PADS*$bits(pad_cnt_t)-1:0]   in_cnts,
    input  pass_t                                  in_pass,
    output logic                                   in_ack,

    output logic                                   out_req,
    input  logic                                   out_ack,
    output pass_t                                  out_pass,
    output logic                                   out_vpf,
    output pad_cnt_t                               out_cnt,
    output logic [ADR_BITS-1:0]                    out_adr
);

    //--------------------------------------------------
    // Internal links
    //--------------------------------------------------
    logic                                 space_ok;
    logic                                 frame_valid;
    logic [NUM_PADS-1:0]                  frame_vpfs;
    logic [NUM_PADS*$bits(pad_cnt_t)-1:0] frame_cnts;
    pass_t                                frame_pass;

    logic                                 res_valid;
    pass_t                                res_pass;
    logic                                 res_vpf;
    pad_cnt_t                             res_cnt;
    logic [ADR_BITS-1:0]                  res_adr;

    logic                                 fifo_pop;
    logic                                 fifo_empty;
    pass_t                                head_pass;
    logic                                 head_vpf;
    pad_cnt_t                             head_cnt;
    logic [ADR_BITS-1:0]                  head_adr;

    frame_receiver #(
        .NUM_PADS (NUM_PADS)
    ) frame_receiver_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .in_req      (in_req),
        .in_vpfs     (in_vpfs),
        .in_cnts     (in_cnts),
        .in_pass     (in_pass),
        .in_ack      (in_ack),
        .space_ok    (space_ok),
        .frame_valid (frame_valid),
        .frame_vpfs  (frame_vpfs),
        .frame_cnts  (frame_cnts),
        .frame_pass  (frame_pass)
    );

    priority_tree #(
        .NUM_PADS (NUM_PADS),
        .ADR_BITS (ADR_BITS)
    ) priority_tree_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .frame_valid (frame_valid),
        .frame_vpfs  (frame_vpfs),
        .frame_cnts  (frame_cnts),
        .frame_pass  (frame_pass),
        .res_valid   (res_valid),
        .res_pass    (res_pass),
        .res_vpf     (res_vpf),
        .res_cnt     (res_cnt),
        .res_adr     (res_adr)
    );

    result_fifo #(
        .ADR_BITS   (ADR_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) result_fifo_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .res_valid  (res_valid),
        .res_pass   (res_pass),
        .res_vpf    (res_vpf),
        .res_cnt    (res_cnt),
        .res_adr    (res_adr),
        .fifo_pop   (fifo_pop),
        .fifo_empty (fifo_empty),
        .head_pass  (head_pass),
        .head_vpf   (head_vpf),
        .head_cnt   (head_cnt),
        .head_adr   (head_adr),
        .space_ok   (space_ok)
    );

    result_sender #(
        .ADR_BITS (ADR_BITS)
    ) result_sender_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .fifo_empty (fifo_empty),
        .head_pass  (head_pass),
        .head_vpf   (head_vpf),
        .head_cnt   (head_cnt),
        .head_adr   (head_adr),
        .fifo_pop   (fifo_pop),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_pass   (out_pass),
        .out_vpf    (out_vpf),
        .out_cnt    (out_cnt),
        .out_adr    (out_adr)
    );

endmodule

// File: source/result_sender.sv
`timescale 1ns/1ns
module result_sender
    import cluster_pkg::*;
#(
    parameter int ADR_BITS = 5
) (
    input  logic                clock,
    input  logic                arst_n,

    input  logic                fifo_empty,
    input  pass_t               head_pass,
    input  logic                head_vpf,
    input  pad_cnt_t            head_cnt,
    input  logic [ADR_BITS-1:0] head_adr,
    output logic                fifo_pop,

    output logic                out_req,
    input  logic                out_ack,
    output pass_t               out_pass,
    output logic                out_vpf,
    output pad_cnt_t            out_cnt,
    output logic [ADR_BITS-1:0] out_adr
);

    hs_state_t state;

    // Pop in the same cycle the head is latched
    assign fifo_pop = (state == hs_idle) && !fifo_empty;
    assign out_req  = (state == hs_ack);

    //--------------------------------------------------
    // Handshake FSM
    //--------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= hs_idle;
        end else begin
            case (state)
                hs_idle: begin
                    if (!fifo_empty) begin
                        state <= hs_ack;
                    end
                end
                hs_ack: begin
                    if (out_ack) begin
                        state <= hs_wait;
                    end
                end
                hs_wait: begin
                    // Return to zero before the next result
                    if (!out_ack) begin
                        state <= hs_idle;
                    end
                end
                default: begin
                    state <= hs_idle;
                end
            endcase
        end
    end

    // Output registers hold the result while the FIFO moves on
    always_ff @(posedge clock) begin
        if (fifo_pop) begin
            out_pass <= head_pass;
            out_vpf  <= head_vpf;
            out_cnt  <= head_cnt;
            out_adr  <= head_adr;
        end
    end

endmodule

// File: source/result_fifo.sv
`timescale 1ns/1ns
module result_fifo
    import cluster_pkg::*;
#(
    parameter int ADR_BITS   = 5,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clock,
    input  logic                arst_n,

    input  logic                res_valid,
    input  pass_t               res_pass,
    input  logic                res_vpf,
    input  pad_cnt_t            res_cnt,
    input  logic [ADR_BITS-1:0] res_adr,

    input  logic                fifo_pop,
    output logic                fifo_empty,
    output pass_t               head_pass,
    output logic                head_vpf,
    output pad_cnt_t            head_cnt,
    output logic [ADR_BITS-1:0] head_adr,

    output logic                space_ok
);

    localparam int PTR_BITS   = $clog2(FIFO_DEPTH);
    localparam int CNT_BITS   = $clog2(FIFO_DEPTH + 1);
    localparam int ENTRY_BITS = $bits(pass_t) + 1 + $bits(pad_cnt_t) + ADR_BITS;

    logic [ENTRY_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [CNT_BITS-1:0]   count;
    logic                  do_write;
    logic                  do_pop;

    assign do_write = res_valid && (count != CNT_BITS'(FIFO_DEPTH));
    assign do_pop   = fifo_pop && (count != '0);

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= {res_pass, res_vpf, res_cnt, res_adr};
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign fifo_empty = (count == '0);
    assign {head_pass, head_vpf, head_cnt, head_adr} = mem[rd_ptr];

    // Keep room for two frames in the tree and one being accepted
    assign space_ok = (count <= CNT_BITS'(FIFO_DEPTH - 3));

endmodule

// File: source/priority_tree.sv
`timescale 1ns/1ns
module priority_tree
    import cluster_pkg::*;
#(
    parameter int NUM_PADS = 24,
    parameter int ADR_BITS = 5
) (
    input  logic                                   clock,
    input  logic                                   arst_n,

    input  logic                                   frame_valid,
    input  logic [NUM_PADS-1:0]                    frame_vpfs,
    input  logic [NUM_PADS*$bits(pad_cnt_t)-1:0]   frame_cnts,
    input  pass_t                                  frame_pass,

    output logic                                   res_valid,
    output pass_t                                  res_pass,
    output logic                                   res_vpf,
    output pad_cnt_t                               res_cnt,
    output logic [ADR_BITS-1:0]                    res_adr
);

    // Halving stages down to three groups, NUM_PADS = 3 * 2**STAGES
    localparam int STAGES    = $clog2(NUM_PADS / 3);
    // Second register rank sits after this stage
    localparam int MID       = (STAGES + 2) / 2;
    localparam int CNT_BITS  = $bits(pad_cnt_t);
    // Node layout is {vpf, cnt, key}
    localparam int NODE_BITS = 1 + CNT_BITS + ADR_BITS;

    logic [NODE_BITS-1:0] lvl [0:STAGES][NUM_PADS];

    logic  valid_q1;
    logic  valid_q2;
    pass_t pass_q1;
    pass_t pass_q2;

    // Keep the even node if its flag is set, else take the odd one and mark key bit
    function automatic logic [NODE_BITS-1:0] pick(
        input logic [NODE_BITS-1:0] even_node,
        input logic [NODE_BITS-1:0] odd_node,
        input int                   stage
    );
        logic [NODE_BITS-1:0] node;
        if (even_node[NODE_BITS-1]) begin
            node = even_node;
        end else begin
            node = odd_node;
            node[stage-1] = 1'b1;
        end
        return node;
    endfunction

    // Unpack the flat count vector, keys start at zero
    always_comb begin
        for (int i = 0; i < NUM_PADS; i++) begin
            lvl[0][i] = {frame_vpfs[i], frame_cnts[i*CNT_BITS +: CNT_BITS], ADR_BITS'(0)};
        end
    end

    //--------------------------------------------------
    // Pairwise compare stages
    //--------------------------------------------------
    for (genvar s = 1; s <= STAGES; s++) begin : g_stage
        localparam int NOUT = NUM_PADS >> s;

        logic [NODE_BITS-1:0] pair [NOUT];

        always_comb begin
            for (int i = 0; i < NOUT; i++) begin
                pair[i] = pick(lvl[s-1][2*i], lvl[s-1][2*i+1], s);
            end
        end

        if (s == 1 || s == MID) begin : g_reg
            logic [NODE_BITS-1:0] pair_q [NOUT];

            always_ff @(posedge clock) begin
                pair_q <= pair;
            end

            always_comb begin
                for (int i = 0; i < NOUT; i++) begin
                    lvl[s][i] = pair_q[i];
                end
                for (int i = NOUT; i < NUM_PADS; i++) begin
                    lvl[s][i] = '0;
                end
            end
        end else begin : g_comb
            always_comb begin
                for (int i = 0; i < NOUT; i++) begin
                    lvl[s][i] = pair[i];
                end
                for (int i = NOUT; i < NUM_PADS; i++) begin
                    lvl[s][i] = '0;
                end
            end
        end
    end

    // Valid and pass follow the two register ranks
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            valid_q1 <= frame_valid;
            valid_q2 <= valid_q1;
        end
    end

    always_ff @(posedge clock) begin
        pass_q1 <= frame_pass;
        pass_q2 <= pass_q1;
    end

    //--------------------------------------------------
    // 1-of-3 encoder, group number goes on top of the key
    //--------------------------------------------------
    always_comb begin
        res_vpf = 1'b0;
        res_cnt = '0;
        res_adr = '1;
        for (int g = 2; g >= 0; g--) begin
            // Walk down so the lowest valid group wins
            if (lvl[STAGES][g][NODE_BITS-1]) begin
                res_vpf = 1'b1;
                res_cnt = lvl[STAGES][g][ADR_BITS +: CNT_BITS];
                res_adr = lvl[STAGES][g][ADR_BITS-1:0] | (ADR_BITS'(g) << STAGES);
            end
        end
    end

    assign res_valid = valid_q2;
    assign res_pass  = pass_q2;

endmodule

// File: source/frame_receiver.sv
`timescale 1ns/1ns
module frame_receiver
    import cluster_pkg::*;
#(
    parameter int NUM_PADS = 24
) (
    input  logic                                   clock,
    input  logic                                   arst_n,

    input  logic                                   in_req,
    input  logic [NUM_PADS-1:0]                    in_vpfs,
    input  logic [NUM_PADS*$bits(pad_cnt_t)-1:0]   in_cnts,
    input  pass_t                                  in_pass,
    output logic                                   in_ack,

    input  logic                                   space_ok,

    output logic                                   frame_valid,
    output logic [NUM_PADS-1:0]                    frame_vpfs,
    output logic [NUM_PADS*$bits(pad_cnt_t)-1:0]   frame_cnts,
    output pass_t                                  frame_pass
);

    hs_state_t state;
    logic      accept;

    // Take a frame only while the FIFO can absorb its result
    assign accept = (state == hs_idle) && in_req && space_ok;
    assign in_ack = (state == hs_ack);

    //--------------------------------------------------
    // Handshake FSM
    //--------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= hs_idle;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= accept;
            case (state)
                hs_idle: begin
                    if (accept) begin
                        state <= hs_ack;
                    end
                end
                hs_ack: begin
                    // Source has seen the acknowledge and released the request
                    if (!in_req) begin
                        state <= hs_idle;
                    end
                end
                default: begin
                    state <= hs_idle;
                end
            endcase
        end
    end

    // Frame register, so the source is free once in_ack is seen
    always_ff @(posedge clock) begin
        if (accept) begin
            frame_vpfs <= in_vpfs;
            frame_cnts <= in_cnts;
            frame_pass <= in_pass;
        end
    end

endmodule

// File: source/cluster_pkg.sv
package cluster_pkg;

    // Charge count carried by one pad
    typedef logic [2:0] pad_cnt_t;

    // Pass tag, carried unchanged from frame to result
    typedef logic [2:0] pass_t;

    // Four-phase handshake states
    // hs_ack holds the active acknowledge or request phase,
    // hs_wait is the return-to-zero phase of the sender
    typedef enum logic [1:0] {
        hs_idle = 2'd0,
        hs_ack  = 2'd1,
        hs_wait = 2'd2
    } hs_state_t;

endpackage
